// File: src/isa_pkg.sv
package isa_pkg;

    // datapath widths
    localparam int xlen   = 32;
    localparam int addr_w = 32;
    localparam int reg_w  = 5;

    // dispatch operation code
    localparam int op_w = 6;

    // store forms, the only ops the buffer treats specially
    localparam logic [op_w-1:0] op_sb = 6'd26;
    localparam logic [op_w-1:0] op_sh = 6'd27;
    localparam logic [op_w-1:0] op_sw = 6'd28;

    // collapses the op to a single store flag
    function automatic logic is_store(input logic [op_w-1:0] op);
        logic st;
        case (op)
            op_sb,
            op_sh,
            op_sw:   st = 1'b1;
            default: st = 1'b0;
        endcase
        return st;
    endfunction

endpackage

// File: src/rob_pkg.sv
package rob_pkg;

    localparam int tag_w     = 5;
    localparam int rob_depth = 31;

    // tag 0 stays free to mean no tag
    localparam logic [tag_w-1:0] first_tag = 1;

    // wraps from the last entry back to 1
    function automatic logic [tag_w-1:0] next_tag(input logic [tag_w-1:0] t);
        return (t == tag_w'(rob_depth)) ? first_tag : t + 1'b1;
    endfunction

    typedef struct packed {
        logic                      valid;
        logic [tag_w-1:0]          tag;
        logic [isa_pkg::reg_w-1:0] rd;
    } alloc_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic             store;
        logic             pred;
    } dispatch_t;

    typedef struct packed {
        logic                       valid;
        logic [tag_w-1:0]           tag;
        logic [isa_pkg::xlen-1:0]   data;
        logic                       taken;
        logic [isa_pkg::addr_w-1:0] target;
    } result_t;

    typedef struct packed {
        logic                       occupied;
        logic                       done;
        logic                       store;
        logic                       released;
        logic                       pred;
        logic                       actual;
        logic [isa_pkg::reg_w-1:0]  rd;
        logic [isa_pkg::xlen-1:0]   data;
        logic [isa_pkg::addr_w-1:0] target;
    } entry_t;

    typedef struct packed {
        logic retire;
        logic rel;
        logic flush;
    } retire_t;

endpackage

// File: src/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,
    input  logic                      clr,
    input  logic                      tag_req,
    input  logic [isa_pkg::reg_w-1:0] tag_rd,
    input  logic                      dp_en,
    input  logic [rob_pkg::tag_w-1:0] dp_tag,
    input  logic [isa_pkg::op_w-1:0]  dp_op,
    input  logic                      dp_pred,
    input  rob_pkg::retire_t          retire,
    output logic                      tag_en,
    output logic [rob_pkg::tag_w-1:0] tag,
    output logic                      full,
    output rob_pkg::alloc_t           alloc,
    output rob_pkg::dispatch_t        dispatch
);
    import isa_pkg::*;
    import rob_pkg::*;

    logic [tag_w-1:0] tail;
    logic [tag_w-1:0] count;
    logic             grant;

    assign full  = (count == tag_w'(rob_depth));
    assign grant = rdy && tag_req && !full;

    assign tag_en = grant;
    assign tag    = grant ? tail : '0;

    always_comb begin
        alloc.valid = grant;
        alloc.tag   = tail;
        alloc.rd    = tag_rd;
    end

    // entries only keep the decoded store bit
    always_comb begin
        dispatch.valid = rdy && dp_en;
        dispatch.tag   = dp_tag;
        dispatch.store = is_store(dp_op);
        dispatch.pred  = dp_pred;
    end

    always_ff @(posedge clk) begin
        if (rst || clr || retire.flush) begin
            tail  <= first_tag;
            count <= '0;
        end else begin
            if (grant) begin
                tail <= next_tag(tail);
            end
            case ({grant, retire.retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/rob_entries.sv
`timescale 1ns/1ps

module rob_entries (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rdy,
    input  logic                      clr,
    input  rob_pkg::alloc_t           alloc,
    input  rob_pkg::dispatch_t        dispatch,
    input  rob_pkg::result_t          ex_res,
    input  logic                      slb_done,
    input  logic [rob_pkg::tag_w-1:0] slb_tag,
    input  rob_pkg::retire_t          retire,
    output rob_pkg::entry_t           head,
    output logic [rob_pkg::tag_w-1:0] head_tag
);
    import rob_pkg::*;

    // indexed directly by tag, slot 0 does not exist
    entry_t           entries [1:rob_depth];
    logic [tag_w-1:0] head_ptr;

    // an empty head during clr keeps the commit side quiet
    assign head     = clr ? '0 : entries[head_ptr];
    assign head_tag = head_ptr;

    always_ff @(posedge clk) begin
        if (rst || clr || retire.flush) begin
            for (int i = 1; i <= rob_depth; i++) begin
                entries[i] <= '0;
            end
            head_ptr <= first_tag;
        end else if (rdy) begin
            // new tag from decode
            if (alloc.valid) begin
                entries[alloc.tag] <= '{occupied: 1'b1, rd: alloc.rd, default: '0};
            end

            if (dispatch.valid) begin
                entries[dispatch.tag].store <= dispatch.store;
                entries[dispatch.tag].pred  <= dispatch.pred;
            end

            // stale results after a flush find no occupied entry
            if (ex_res.valid && entries[ex_res.tag].occupied) begin
                entries[ex_res.tag].data   <= ex_res.data;
                entries[ex_res.tag].actual <= ex_res.taken;
                entries[ex_res.tag].target <= ex_res.target;
                if (!entries[ex_res.tag].store) begin
                    entries[ex_res.tag].done <= 1'b1;
                end
            end

            // stores complete only through the store buffer
            if (slb_done && entries[slb_tag].store) begin
                entries[slb_tag].done <= 1'b1;
            end

            if (retire.rel) begin
                entries[head_ptr].released <= 1'b1;
            end

            if (retire.retire) begin
                entries[head_ptr] <= '0;
                head_ptr          <= next_tag(head_ptr);
            end
        end
    end

endmodule

// File: src/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rdy,
    input  rob_pkg::entry_t            head,
    input  logic [rob_pkg::tag_w-1:0]  head_tag,
    output rob_pkg::retire_t           retire,
    output logic                       rf_wr,
    output logic [isa_pkg::reg_w-1:0]  rf_rd,
    output logic [isa_pkg::xlen-1:0]   rf_data,
    output logic [rob_pkg::tag_w-1:0]  rf_tag,
    output logic                       store_go,
    output logic [rob_pkg::tag_w-1:0]  store_tag,
    output logic                       flush,
    output logic [isa_pkg::addr_w-1:0] redirect_pc
);

    typedef enum logic [2:0] {
        c_wait,
        c_release,
        c_store_done,
        c_normal,
        c_mispred
    } class_e;

    class_e cls;
    logic   rf_wr_q;
    logic   store_go_q;
    logic   flush_q;

    always_comb begin
        cls = c_wait;
        if (head.occupied) begin
            if (head.store) begin
                if (!head.released) begin
                    cls = c_release;
                end else if (head.done) begin
                    cls = c_store_done;
                end
            end else if (head.done) begin
                // prediction checked here only
                cls = (head.pred != head.actual) ? c_mispred : c_normal;
            end
        end
    end

    always_comb begin
        retire.retire = rdy && (cls inside {c_store_done, c_normal, c_mispred});
        retire.rel    = rdy && (cls == c_release);
        retire.flush  = rdy && (cls == c_mispred);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_wr_q    <= 1'b0;
            store_go_q <= 1'b0;
            flush_q    <= 1'b0;
        end else if (rdy) begin
            rf_wr_q    <= (cls == c_normal) || (cls == c_mispred);
            store_go_q <= (cls == c_release);
            flush_q    <= (cls == c_mispred);
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && (cls == c_normal || cls == c_mispred)) begin
            rf_rd   <= head.rd;
            rf_data <= head.data;
            rf_tag  <= head_tag;
        end
        if (rdy && cls == c_release) begin
            store_tag <= head_tag;
        end
        if (rdy && cls == c_mispred) begin
            redirect_pc <= head.target;
        end
    end

    // a pulse caught by a stall shows up once rdy returns
    assign rf_wr    = rf_wr_q && rdy;
    assign store_go = store_go_q && rdy;
    assign flush    = flush_q && rdy;

endmodule

// File: src/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rdy,
    input  logic                       clr,
    // decode
    input  logic                       tag_req,
    input  logic [isa_pkg::reg_w-1:0]  tag_rd,
    output logic                       tag_en,
    output logic [rob_pkg::tag_w-1:0]  tag,
    output logic                       full,
    // dispatch
    input  logic                       dp_en,
    input  logic [rob_pkg::tag_w-1:0]  dp_tag,
    input  logic [isa_pkg::op_w-1:0]   dp_op,
    input  logic                       dp_pred,
    // execution and store buffer
    input  rob_pkg::result_t           ex_res,
    input  logic                       slb_done,
    input  logic [rob_pkg::tag_w-1:0]  slb_tag,
    // commit
    output logic                       rf_wr,
    output logic [isa_pkg::reg_w-1:0]  rf_rd,
    output logic [isa_pkg::xlen-1:0]   rf_data,
    output logic [rob_pkg::tag_w-1:0]  rf_tag,
    output logic                       store_go,
    output logic [rob_pkg::tag_w-1:0]  store_tag,
    output logic                       flush,
    output logic [isa_pkg::addr_w-1:0] redirect_pc
);
    import rob_pkg::*;

    alloc_t           alloc;
    dispatch_t        dispatch;
    entry_t           head;
    logic [tag_w-1:0] head_tag;
    retire_t          retire;

    rob_alloc i_alloc (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .clr      (clr),
        .tag_req  (tag_req),
        .tag_rd   (tag_rd),
        .dp_en    (dp_en),
        .dp_tag   (dp_tag),
        .dp_op    (dp_op),
        .dp_pred  (dp_pred),
        .retire   (retire),
        .tag_en   (tag_en),
        .tag      (tag),
        .full     (full),
        .alloc    (alloc),
        .dispatch (dispatch)
    );

    rob_entries i_entries (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .clr      (clr),
        .alloc    (alloc),
        .dispatch (dispatch),
        .ex_res   (ex_res),
        .slb_done (slb_done),
        .slb_tag  (slb_tag),
        .retire   (retire),
        .head     (head),
        .head_tag (head_tag)
    );

    rob_commit i_commit (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .head        (head),
        .head_tag    (head_tag),
        .retire      (retire),
        .rf_wr       (rf_wr),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .rf_tag      (rf_tag),
        .store_go    (store_go),
        .store_tag   (store_tag),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: sim/tb_rob.sv
`timescale 1ns/1ps

module tb_rob;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam time clk_period = 20;

    typedef enum {k_req, k_disp, k_res, k_slb, k_clr, k_stall, k_idle, k_drain} step_kind_e;

    // tag is the expected grant for a request, 0 when it must be refused
    typedef struct {
        step_kind_e        kind;
        logic [tag_w-1:0]  tag;
        logic [reg_w-1:0]  rd;
        logic [op_w-1:0]   op;
        logic              flag;
        logic [xlen-1:0]   data;
        logic [addr_w-1:0] target;
        int                n;
    } step_t;

    typedef struct {
        logic [tag_w-1:0]  tag;
        logic [reg_w-1:0]  rd;
        logic              store;
        logic              pred;
        logic              taken;
        logic [xlen-1:0]   data;
        logic [addr_w-1:0] target;
        logic              released;
        logic              slb;
        time               res_time;
    } exp_t;

    logic clk, rst, rdy, clr, tag_req, tag_en, full, dp_en, dp_pred, slb_done;
    logic rf_wr, store_go, flush;
    logic [reg_w-1:0]  tag_rd, rf_rd;
    logic [tag_w-1:0]  tag, dp_tag, slb_tag, rf_tag, store_tag;
    logic [op_w-1:0]   dp_op;
    logic [xlen-1:0]   rf_data;
    logic [addr_w-1:0] redirect_pc;
    result_t           ex_res;

    step_t       steps[$];
    exp_t        exp_q[$];
    logic [31:0] seed = 32'h5fbc72e2;
    logic        built;

    rob_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int find_live(input logic [tag_w-1:0] t);
        int idx;
        idx = -1;
        foreach (exp_q[i]) begin
            if (exp_q[i].tag == t) idx = i;
        end
        return idx;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        abort_run($sformatf("error at %0d ns: %s = 0x%0h, expected 0x%0h",
                            $time, name, got, want));
    endtask

    task automatic check_grant(input logic en, input logic [tag_w-1:0] got,
                               input logic [tag_w-1:0] want);
        if (en !== (want != '0)) value_error("tag_en", 32'(en), 32'(want != '0));
        else if (en && got !== want) value_error("tag", 32'(got), 32'(want));
    endtask

    task automatic check_commit(input logic [tag_w-1:0] t, input logic [reg_w-1:0] rd,
                                input logic [xlen-1:0] data, input exp_t e);
        if (t !== e.tag) value_error("rf_tag", 32'(t), 32'(e.tag));
        else if (rd !== e.rd) value_error("rf_rd", 32'(rd), 32'(e.rd));
        else if (data !== e.data) value_error("rf_data", data, e.data);
    endtask

    task automatic check_store(input logic [tag_w-1:0] got, input logic [tag_w-1:0] want);
        if (got !== want) value_error("store_tag", 32'(got), 32'(want));
    endtask

    task automatic check_redirect(input logic [addr_w-1:0] got, input logic [addr_w-1:0] want);
        if (got !== want) value_error("redirect_pc", got, want);
    endtask

    task automatic add_step(input step_kind_e kind, input int t = 0, input int a = 0,
                            input logic f = 1'b0, input logic [31:0] d = '0,
                            input logic [31:0] tgt = '0);
        step_t s;
        s.kind   = kind;
        s.tag    = tag_w'(t);
        s.rd     = reg_w'(a);
        s.op     = op_w'(a);
        s.flag   = f;
        s.data   = d;
        s.target = tgt;
        s.n      = a;
        steps.push_back(s);
    endtask

    task automatic build_table();
        int order [4];
        int j;
        int tmp;
        int t;
        // four results completed in shuffled order
        for (int i = 1; i <= 4; i++) add_step(k_req, i, i + 8);
        for (int i = 1; i <= 4; i++) add_step(k_disp, i, 0);
        order = '{1, 2, 3, 4};
        for (int i = 3; i > 0; i--) begin
            seed = lcg_next(seed);
            j = int'(seed[31:16]) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 4; i++) begin
            seed = lcg_next(seed);
            add_step(k_res, order[i], 0, 1'b0, seed);
        end
        add_step(k_drain);
        // fill all entries, wrapping past 31
        t = 5;
        for (int i = 0; i < rob_depth; i++) begin
            add_step(k_req, t, i);
            t = (t == rob_depth) ? 1 : t + 1;
        end
        add_step(k_req, 0, 7);
        add_step(k_disp, 5, 0);
        add_step(k_res, 5, 0, 1'b0, 32'h0000_0555);
        add_step(k_req, 5, 9);
        add_step(k_clr);
        // store at the head holds back tags 2 and 3
        for (int i = 1; i <= 3; i++) add_step(k_req, i, i + 4);
        add_step(k_disp, 1, int'(op_sw));
        add_step(k_disp, 2, 0);
        add_step(k_disp, 3, 0);
        add_step(k_res, 2, 0, 1'b0, 32'h0000_0222);
        add_step(k_res, 3, 0, 1'b0, 32'h0000_0333);
        add_step(k_res, 1, 0, 1'b0, 32'h0000_0111);
        add_step(k_idle, 0, 6);
        add_step(k_slb, 1);
        add_step(k_drain);
        // branch 5 mispredicts, tag 6 is already done but must vanish
        for (int i = 4; i <= 6; i++) add_step(k_req, i, i + 4);
        for (int i = 4; i <= 6; i++) add_step(k_disp, i, 0);
        add_step(k_res, 6, 0, 1'b0, 32'h0000_0666);
        add_step(k_res, 4, 0, 1'b0, 32'h0000_0444);
        add_step(k_res, 5, 0, 1'b1, 32'h0000_1238, 32'h0000_2468);
        add_step(k_drain);
        // stall just as tag 1 commits
        add_step(k_req, 1, 11);
        add_step(k_req, 2, 12);
        add_step(k_disp, 1, 0);
        add_step(k_disp, 2, 0);
        add_step(k_res, 1, 0, 1'b0, 32'h0001_0111);
        add_step(k_res, 2, 0, 1'b0, 32'h0002_0222);
        add_step(k_stall, 0, 4);
        add_step(k_drain);
    endtask

    task automatic update_model(input step_t s);
        exp_t e;
        int   idx;
        idx = find_live(s.tag);
        if (s.kind == k_req && s.tag != '0) begin
            e = '{default: '0};
            e.tag = s.tag;
            e.rd  = s.rd;
            exp_q.push_back(e);
        end else if (s.kind == k_clr) begin
            exp_q.delete();
        end else if (s.kind inside {k_disp, k_res, k_slb}) begin
            if (idx < 0) begin
                abort_run("a table step refers to a tag that is not live");
            end else begin
                e = exp_q[idx];
                if (s.kind == k_disp) begin
                    e.store = (s.op == op_sb) || (s.op == op_sh) || (s.op == op_sw);
                    e.pred  = s.flag;
                end else if (s.kind == k_res) begin
                    e.data     = s.data;
                    e.taken    = s.flag;
                    e.target   = s.target;
                    e.res_time = $time;
                end else begin
                    e.slb = 1'b1;
                end
                exp_q[idx] = e;
            end
        end
    endtask

    task automatic run_step(input step_t s);
        @(posedge clk);
        tag_req  <= 1'b0;
        dp_en    <= 1'b0;
        ex_res   <= '0;
        slb_done <= 1'b0;
        clr      <= 1'b0;
        rdy      <= 1'b1;
        update_model(s);
        case (s.kind)
            k_req: begin
                tag_req <= 1'b1;
                tag_rd  <= s.rd;
                @(negedge clk);
                // requester holds until full drops
                while (s.tag != '0 && !tag_en) begin
                    @(posedge clk);
                    @(negedge clk);
                end
                check_grant(tag_en, tag, s.tag);
                if (s.tag == '0 && !full) abort_run("request refused while full is low");
            end
            k_disp: begin
                dp_en   <= 1'b1;
                dp_tag  <= s.tag;
                dp_op   <= s.op;
                dp_pred <= s.flag;
            end
            k_res: ex_res <= '{valid: 1'b1, tag: s.tag, data: s.data, taken: s.flag,
                               target: s.target};
            k_slb: begin
                slb_done <= 1'b1;
                slb_tag  <= s.tag;
            end
            k_clr: clr <= 1'b1;
            k_stall: begin
                rdy <= 1'b0;
                repeat (s.n - 1) @(posedge clk);
            end
            k_idle: repeat (s.n - 1) @(posedge clk);
            default: while (exp_q.size() != 0) @(posedge clk);
        endcase
    endtask

    task automatic check_outputs();
        exp_t e;
        logic mis;
        mis = 1'b0;
        if (!rdy && (rf_wr || store_go || flush)) abort_run("pulse output seen while rdy is low");
        // finished stores leave silently
        while (exp_q.size() != 0 && exp_q[0].store && exp_q[0].released && exp_q[0].slb) begin
            e = exp_q.pop_front();
        end
        if (store_go) begin
            if (exp_q.size() == 0 || !exp_q[0].store || exp_q[0].released) begin
                abort_run("store_go without an unreleased store at the head");
            end else begin
                check_store(store_tag, exp_q[0].tag);
                e = exp_q[0];
                e.released = 1'b1;
                exp_q[0] = e;
            end
        end
        if (rf_wr) begin
            if (exp_q.size() == 0) begin
                abort_run("rf_wr while no commit is pending");
            end else begin
                e = exp_q.pop_front();
                if (e.store) abort_run("register commit overtook a store at the head");
                check_commit(rf_tag, rf_rd, rf_data, e);
                mis = (e.pred != e.taken);
                if (mis) begin
                    check_redirect(redirect_pc, e.target);
                    if ($time != e.res_time + 5 * clk_period / 2) begin
                        abort_run("flush did not come one cycle after the branch completed");
                    end
                    exp_q.delete();
                end
            end
        end
        if (flush !== mis) abort_run("flush does not match a mispredicted branch commit");
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) check_outputs();
        end
    end

    // limit scales with the table length
    initial begin
        wait (built);
        repeat (steps.size() * 40) @(posedge clk);
        abort_run("watchdog expired before the test finished");
    end

    initial begin
        rst      = 1'b1;
        rdy      = 1'b1;
        clr      = 1'b0;
        tag_req  = 1'b0;
        tag_rd   = '0;
        dp_en    = 1'b0;
        dp_tag   = '0;
        dp_op    = '0;
        dp_pred  = 1'b0;
        ex_res   = '0;
        slb_done = 1'b0;
        slb_tag  = '0;
        built    = 1'b0;
        build_table();
        built = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (tag_en || full || rf_wr || store_go || flush) abort_run("outputs not idle after reset");
        foreach (steps[i]) run_step(steps[i]);
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            abort_run("expected commits still pending at the end");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: all.f
src/isa_pkg.sv
src/rob_pkg.sv
src/rob_alloc.sv
src/rob_entries.sv
src/rob_commit.sv
src/rob_top.sv
sim/tb_rob.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_rob -f all.f -o tb_rob
status=0
./obj_dir/tb_rob > sim.log 2>&1 || status=$?
cat sim.log
if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished cleanly"
